/* hdl/bridge_pkg.sv */
package bridge_pkg;

    typedef logic [31:0] word_t;   // one bus data word
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [3:0]  strb_t;   // byte enables
    typedef logic [2:0]  axsize_t; // AXI size code

    localparam axsize_t SIZE_WORD = 3'd2; // four bytes per beat

    // transfer size implied by a byte-enable pattern
    function automatic axsize_t size_from_strb(input strb_t strb);
        axsize_t size;
        case (strb)
            4'b0001,
            4'b0010,
            4'b0100,
            4'b1000: begin
                size = 3'd0; // single byte
            end
            4'b0011,
            4'b1100: begin
                size = 3'd1; // aligned half word
            end
            default: begin
                size = SIZE_WORD;
            end
        endcase
        return size;
    endfunction

endpackage

/* hdl/bridge_ifs.sv */
`timescale 1ns/1ps

// one bus job handed from the request side to an engine
interface job_if
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
);
    logic                     start;   // one-cycle pulse
    addr_t                    addr;
    logic                     is_line; // line burst vs single word
    logic [LINE_WORDS*32-1:0] line;
    word_t                    word;
    strb_t                    strb;
    logic                     done;    // one-cycle pulse from engine

    modport src (
        output start, addr, is_line, line, word, strb,
        input  done
    );

    modport eng (
        input  start, addr, is_line, line, word, strb,
        output done
    );
endinterface

// read data going from the read engine to the deliver stage
interface rd_result_if
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
);
    logic                     valid;
    logic                     is_line;
    logic [LINE_WORDS*32-1:0] line;
    word_t                    word;

    modport eng (
        output valid, is_line, line, word
    );

    modport dlv (
        input  valid, is_line, line, word
    );
endinterface

/* hdl/req_capture.sv */
`timescale 1ns/1ps

module req_capture
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dcache_ren,
    input  addr_t                    dcache_raddr,
    input  logic                     dcache_wen,
    input  addr_t                    dcache_waddr,
    input  logic [LINE_WORDS*32-1:0] dcache_line_old,
    input  logic                     uncache_en,
    input  strb_t                    uncache_wen,
    input  addr_t                    uncache_addr,
    input  word_t                    uncache_wdata,
    job_if.src                       wr_job,
    job_if.src                       rd_job
);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} seq_state_t;

    seq_state_t state;
    logic       wr_start;
    logic       rd_start;
    logic       need_rd_q;

    logic dc_req;  // data cache wins over uncached
    logic need_wr;
    logic need_rd;
    logic any_req;

    addr_t                    wr_addr_q;
    addr_t                    rd_addr_q;
    logic                     wr_line_q;
    logic                     rd_line_q;
    logic [LINE_WORDS*32-1:0] line_q;
    word_t                    word_q;
    strb_t                    strb_q;

    assign dc_req  = dcache_ren | dcache_wen;
    assign need_wr = dcache_wen | (~dc_req & uncache_en & (|uncache_wen));
    assign need_rd = dcache_ren | (~dc_req & uncache_en & ~(|uncache_wen));
    assign any_req = dc_req | uncache_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            wr_start  <= 1'b0;
            rd_start  <= 1'b0;
            need_rd_q <= 1'b0;
        end else begin
            wr_start <= 1'b0;
            rd_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (any_req) begin
                        need_rd_q <= need_rd;
                        wr_start  <= need_wr;
                        rd_start  <= ~need_wr;
                        state     <= need_wr ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (wr_job.done) begin
                        rd_start <= need_rd_q; // refill after writeback
                        state    <= need_rd_q ? ST_READ : ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (rd_job.done) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && any_req) begin
            wr_addr_q <= dcache_wen ? dcache_waddr : uncache_addr;
            rd_addr_q <= dcache_ren ? dcache_raddr : uncache_addr;
            wr_line_q <= dcache_wen;
            rd_line_q <= dcache_ren;
            line_q    <= dcache_line_old;
            word_q    <= uncache_wdata;
            strb_q    <= uncache_wen;
        end
    end

    assign wr_job.start   = wr_start;
    assign wr_job.addr    = wr_addr_q;
    assign wr_job.is_line = wr_line_q;
    assign wr_job.line    = line_q;
    assign wr_job.word    = word_q;
    assign wr_job.strb    = strb_q;

    assign rd_job.start   = rd_start;
    assign rd_job.addr    = rd_addr_q;
    assign rd_job.is_line = rd_line_q;
    assign rd_job.line    = line_q;
    assign rd_job.word    = word_q;
    assign rd_job.strb    = strb_q;

endmodule

/* hdl/burst_read_engine.sv */
`timescale 1ns/1ps

module burst_read_engine
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic       clk,
    input  logic       rst,
    job_if.eng         rd_job,
    rd_result_if.eng   rd_res,
    output addr_t      araddr,
    output logic [7:0] arlen,
    output axsize_t    arsize,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

    rd_state_t                state;
    logic                     done_q;
    logic                     is_line_q;
    logic [OFF_W-1:0]         offset;   // slot of the next beat
    logic [LINE_WORDS*32-1:0] line_buf;
    logic                     beat_take;

    assign beat_take = rvalid & rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RD_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (rd_job.start) begin
                        arvalid <= 1'b1;
                        state   <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (beat_take && rlast) begin
                        rready <= 1'b0;
                        done_q <= 1'b1;
                        state  <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && rd_job.start) begin
            araddr    <= rd_job.addr;
            arlen     <= rd_job.is_line ? 8'(LINE_WORDS - 1) : 8'd0;
            is_line_q <= rd_job.is_line;
            offset    <= '0;
        end
        if (beat_take) begin
            line_buf[offset*32 +: 32] <= rdata; // single word lands in slot 0
            offset                    <= offset + 1'b1;
        end
    end

    assign arsize = SIZE_WORD;

    assign rd_job.done    = done_q;
    assign rd_res.valid   = done_q;
    assign rd_res.is_line = is_line_q;
    assign rd_res.line    = line_buf;
    assign rd_res.word    = line_buf[31:0];

endmodule

/* hdl/burst_write_engine.sv */
`timescale 1ns/1ps

module burst_write_engine
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic       clk,
    input  logic       rst,
    job_if.eng         wr_job,
    output logic       wr_word_done,
    output addr_t      awaddr,
    output logic [7:0] awlen,
    output axsize_t    awsize,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_t;

    wr_state_t        state;
    logic             done_q;
    logic             is_line_q;
    logic [OFF_W-1:0] offset;    // next line word to send
    logic             beat_take;
    logic             last_slot;

    assign beat_take = wvalid & wready;
    assign last_slot = (offset == OFF_W'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= WR_IDLE;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            wlast        <= 1'b0;
            bready       <= 1'b0;
            done_q       <= 1'b0;
            wr_word_done <= 1'b0;
        end else begin
            done_q       <= 1'b0;
            wr_word_done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (wr_job.start) begin
                        awvalid <= 1'b1;
                        bready  <= 1'b1; // held through to B
                        state   <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                        wvalid  <= 1'b1;
                        wlast   <= ~is_line_q;
                        state   <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (beat_take) begin
                        if (wlast) begin
                            wvalid <= 1'b0;
                            wlast  <= 1'b0;
                            state  <= WR_RESP;
                        end else begin
                            wlast <= last_slot;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        bready       <= 1'b0;
                        done_q       <= 1'b1;
                        wr_word_done <= ~is_line_q;
                        state        <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WR_IDLE && wr_job.start) begin
            awaddr    <= wr_job.addr;
            awlen     <= wr_job.is_line ? 8'(LINE_WORDS - 1) : 8'd0;
            awsize    <= wr_job.is_line ? SIZE_WORD : size_from_strb(wr_job.strb);
            is_line_q <= wr_job.is_line;
        end
        if (state == WR_ADDR && awready) begin
            wdata  <= is_line_q ? wr_job.line[31:0] : wr_job.word;
            wstrb  <= is_line_q ? 4'b1111 : wr_job.strb;
            offset <= OFF_W'(1);
        end
        if (state == WR_DATA && beat_take && !wlast) begin
            wdata  <= wr_job.line[offset*32 +: 32];
            offset <= offset + 1'b1;
        end
    end

    assign wr_job.done = done_q;

endmodule

/* hdl/resp_deliver.sv */
`timescale 1ns/1ps

module resp_deliver
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    rd_result_if.dlv                 rd_res,
    input  logic                     wr_word_done,
    output logic [LINE_WORDS*32-1:0] dcache_line_new,
    output logic                     dcache_refresh,
    output word_t                    uncache_rdata,
    output logic                     uncache_refresh
);

    // completion pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            dcache_refresh  <= 1'b0;
            uncache_refresh <= 1'b0;
        end else begin
            dcache_refresh  <= rd_res.valid & rd_res.is_line;
            uncache_refresh <= (rd_res.valid & ~rd_res.is_line) | wr_word_done;
        end
    end

    // returned data holds until the next completion of its kind
    always_ff @(posedge clk) begin
        if (rd_res.valid) begin
            if (rd_res.is_line) begin
                dcache_line_new <= rd_res.line;
            end else begin
                uncache_rdata <= rd_res.word; // writes leave this alone
            end
        end
    end

endmodule

/* hdl/bus_bridge_top.sv */
`timescale 1ns/1ps

module bus_bridge_top
    import bridge_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic                     clk,
    input  logic                     rst,

    // data cache
    input  logic                     dcache_ren,
    input  addr_t                    dcache_raddr,
    input  logic                     dcache_wen,
    input  addr_t                    dcache_waddr,
    input  logic [LINE_WORDS*32-1:0] dcache_line_old,
    output logic [LINE_WORDS*32-1:0] dcache_line_new,
    output logic                     dcache_refresh,

    // uncached port
    input  logic                     uncache_en,
    input  strb_t                    uncache_wen,
    input  addr_t                    uncache_addr,
    input  word_t                    uncache_wdata,
    output word_t                    uncache_rdata,
    output logic                     uncache_refresh,

    // AXI read channels
    output addr_t                    araddr,
    output logic [7:0]               arlen,
    output axsize_t                  arsize,
    output logic                     arvalid,
    input  logic                     arready,
    input  word_t                    rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,

    // AXI write channels
    output addr_t                    awaddr,
    output logic [7:0]               awlen,
    output axsize_t                  awsize,
    output logic                     awvalid,
    input  logic                     awready,
    output word_t                    wdata,
    output strb_t                    wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready
);

    logic wr_word_done;

    job_if       #(.LINE_WORDS(LINE_WORDS)) wr_job ();
    job_if       #(.LINE_WORDS(LINE_WORDS)) rd_job ();
    rd_result_if #(.LINE_WORDS(LINE_WORDS)) rd_res ();

    req_capture #(.LINE_WORDS(LINE_WORDS)) u_req_capture (
        .clk             (clk),
        .rst             (rst),
        .dcache_ren      (dcache_ren),
        .dcache_raddr    (dcache_raddr),
        .dcache_wen      (dcache_wen),
        .dcache_waddr    (dcache_waddr),
        .dcache_line_old (dcache_line_old),
        .uncache_en      (uncache_en),
        .uncache_wen     (uncache_wen),
        .uncache_addr    (uncache_addr),
        .uncache_wdata   (uncache_wdata),
        .wr_job          (wr_job.src),
        .rd_job          (rd_job.src)
    );

    burst_read_engine #(.LINE_WORDS(LINE_WORDS)) u_read_engine (
        .clk     (clk),
        .rst     (rst),
        .rd_job  (rd_job.eng),
        .rd_res  (rd_res.eng),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    burst_write_engine #(.LINE_WORDS(LINE_WORDS)) u_write_engine (
        .clk          (clk),
        .rst          (rst),
        .wr_job       (wr_job.eng),
        .wr_word_done (wr_word_done),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awsize       (awsize),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    resp_deliver #(.LINE_WORDS(LINE_WORDS)) u_resp_deliver (
        .clk             (clk),
        .rst             (rst),
        .rd_res          (rd_res.dlv),
        .wr_word_done    (wr_word_done),
        .dcache_line_new (dcache_line_new),
        .dcache_refresh  (dcache_refresh),
        .uncache_rdata   (uncache_rdata),
        .uncache_refresh (uncache_refresh)
    );

endmodule

/* test/bus_bridge_asserts.sv */
`timescale 1ns/1ps

module bus_bridge_asserts (
    input logic        clk,
    input logic        rst,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic [7:0]  arlen,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic [7:0]  awlen,
    input logic [2:0]  awsize,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata,
    input logic [3:0]  wstrb,
    input logic        wlast,
    input logic        dcache_refresh,
    input logic        uncache_refresh
);

    int unsigned error_count = 0; // failures seen so far

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
        error_count++;
        $error("AR request dropped or changed before arready");
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen) && $stable(awsize))
    else begin
        error_count++;
        $error("AW request dropped or changed before awready");
    end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast))
    else begin
        error_count++;
        $error("W beat dropped or changed before wready");
    end

    wlast_end: assert property (@(posedge clk) disable iff (rst)
        $fell(wlast) |-> $past(wvalid && wready))
    else begin
        error_count++;
        $error("wlast fell without the final beat being taken");
    end

    dref_pulse: assert property (@(posedge clk) disable iff (rst)
        dcache_refresh |=> !dcache_refresh)
    else begin
        error_count++;
        $error("dcache_refresh high for more than one cycle");
    end

    uref_pulse: assert property (@(posedge clk) disable iff (rst)
        uncache_refresh |=> !uncache_refresh)
    else begin
        error_count++;
        $error("uncache_refresh high for more than one cycle");
    end

endmodule

bind bus_bridge_top bus_bridge_asserts u_bus_asserts (
    .clk             (clk),
    .rst             (rst),
    .arvalid         (arvalid),
    .arready         (arready),
    .araddr          (araddr),
    .arlen           (arlen),
    .awvalid         (awvalid),
    .awready         (awready),
    .awaddr          (awaddr),
    .awlen           (awlen),
    .awsize          (awsize),
    .wvalid          (wvalid),
    .wready          (wready),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wlast           (wlast),
    .dcache_refresh  (dcache_refresh),
    .uncache_refresh (uncache_refresh)
);

/* test/tb_bus_bridge.sv */
`timescale 1ns/1ps

module tb_bus_bridge
    import bridge_pkg::*;
();

    localparam int LINE_WORDS    = 16;
    localparam int NUM_OPS       = 200;
    localparam int MEM_WORDS     = 1024;                  // 4 KB of words
    localparam int CYCLES_PER_OP = 2000;
    localparam int MAX_CYCLES    = 2 * NUM_OPS * CYCLES_PER_OP + 100; // read-backs double ops

    logic                     clk;
    logic                     rst;
    logic                     dcache_ren;
    addr_t                    dcache_raddr;
    logic                     dcache_wen;
    addr_t                    dcache_waddr;
    logic [LINE_WORDS*32-1:0] dcache_line_old;
    logic [LINE_WORDS*32-1:0] dcache_line_new;
    logic                     dcache_refresh;
    logic                     uncache_en;
    strb_t                    uncache_wen;
    addr_t                    uncache_addr;
    word_t                    uncache_wdata;
    word_t                    uncache_rdata;
    logic                     uncache_refresh;
    addr_t                    araddr;
    logic [7:0]               arlen;
    axsize_t                  arsize;
    logic                     arvalid;
    logic                     arready;
    word_t                    rdata;
    logic                     rlast;
    logic                     rvalid;
    logic                     rready;
    addr_t                    awaddr;
    logic [7:0]               awlen;
    axsize_t                  awsize;
    logic                     awvalid;
    logic                     awready;
    word_t                    wdata;
    strb_t                    wstrb;
    logic                     wlast;
    logic                     wvalid;
    logic                     wready;
    logic                     bvalid;
    logic                     bready;

    word_t  mem [MEM_WORDS];      // slave memory
    word_t  ref_mem [MEM_WORDS];  // reference copy kept by the checker
    integer seed = 32'hb685;

    addr_t      exp_ar_addr;
    logic [7:0] exp_ar_len;
    addr_t      exp_aw_addr;
    logic [7:0] exp_aw_len;
    logic [2:0] exp_aw_size;
    strb_t      exp_wstrb;
    int         ar_count = 0;
    int         aw_count = 0;
    int         b_count = 0;
    time        ar_time = 0;
    time        b_time = 0;
    int         dref_cnt = 0;
    int         uref_cnt = 0;

    bus_bridge_top #(.LINE_WORDS(LINE_WORDS)) u_dut (.*);

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        abort_run($sformatf("[FAIL] %s expected %h got %h", name, exp, got));
    endtask

    // AXI size from a byte-enable pattern
    function automatic logic [2:0] expected_size(input logic [3:0] strb);
        if ($countones(strb) == 1) return 3'd0;
        if (strb == 4'b0011 || strb == 4'b1100) return 3'd1;
        return 3'd2;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (dcache_refresh) dref_cnt++;
        if (uncache_refresh) uref_cnt++;
    end

    // AXI slave model driving its outputs 1 ns after the edge
    initial begin : axi_slave
        logic ar_hs;
        logic r_hs;
        logic aw_hs;
        logic w_hs;
        logic b_hs;
        logic b_wait;
        int   r_idx;
        int   r_left;
        int   w_idx;
        int   w_cnt;
        int   w_len;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b_wait  = 1'b0;
        r_idx   = 0;
        r_left  = 0;
        w_idx   = 0;
        w_cnt   = 0;
        w_len   = 0;
        forever begin
            @(posedge clk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            b_hs  = bvalid && bready;
            if (ar_hs) begin
                assert (araddr === exp_ar_addr) else flag_mismatch("araddr", exp_ar_addr, araddr);
                assert (arlen === exp_ar_len) else flag_mismatch("arlen", exp_ar_len, arlen);
                assert (arsize === 3'd2) else flag_mismatch("arsize", 32'd2, arsize);
                r_idx  = araddr[11:2];
                r_left = arlen + 1;
            end
            if (r_hs) begin
                r_idx++;
                r_left--;
            end
            if (aw_hs) begin
                assert (awaddr === exp_aw_addr) else flag_mismatch("awaddr", exp_aw_addr, awaddr);
                assert (awlen === exp_aw_len) else flag_mismatch("awlen", exp_aw_len, awlen);
                assert (awsize === exp_aw_size) else flag_mismatch("awsize", exp_aw_size, awsize);
                w_idx = awaddr[11:2];
                w_cnt = 0;
                w_len = awlen;
            end
            if (w_hs) begin
                assert (wstrb === exp_wstrb) else flag_mismatch("wstrb", exp_wstrb, wstrb);
                assert (wlast === (w_cnt == w_len))
                else flag_mismatch("wlast", (w_cnt == w_len), wlast);
                mem[(w_idx + w_cnt) % MEM_WORDS] =
                    merge_bytes(mem[(w_idx + w_cnt) % MEM_WORDS], wdata, wstrb);
                w_cnt++;
                if (wlast) b_wait = 1'b1;
            end
            #1;
            if (ar_hs) begin
                ar_count++;
                ar_time = $time;
            end
            if (aw_hs) aw_count++;
            if (b_hs) begin
                b_count++;
                b_time = $time;
                bvalid = 1'b0;
            end
            if (r_hs) begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
            if (r_left > 0 && !rvalid && ($random(seed) & 3) != 0) begin // random gaps
                rvalid = 1'b1;
                rdata  = mem[r_idx % MEM_WORDS];
                rlast  = (r_left == 1);
            end
            if (b_wait && !bvalid && ($random(seed) & 1)) begin
                bvalid = 1'b1;
                b_wait = 1'b0;
            end
            arready = ($random(seed) & 3) != 0;
            awready = ($random(seed) & 3) != 0;
            wready  = ($random(seed) & 3) != 0;
        end
    end

    // kind is 0 refill, 1 writeback, 2 writeback then refill, 3 uncached read or 4 uncached write
    task automatic run_op(input int kind, input addr_t line_addr, input addr_t word_addr,
                          input strb_t strb, input word_t data);
        int                       base;
        int                       widx;
        int                       b_start;
        int                       ar_start;
        int                       aw_start;
        logic                     noise;
        logic                     use_ar;
        logic                     use_aw;
        word_t                    prev_rdata;
        logic [LINE_WORDS*32-1:0] old_line;
        base   = line_addr[11:2];
        widx   = word_addr[11:2];
        use_ar = (kind == 0 || kind == 2 || kind == 3);
        use_aw = (kind == 1 || kind == 2 || kind == 4);
        noise  = $random(seed) & 1; // uncached request that the dcache one must override
        for (int k = 0; k < LINE_WORDS; k++) old_line[k*32 +: 32] = $random(seed);

        exp_ar_addr = (kind == 3) ? word_addr : line_addr;
        exp_ar_len  = (kind == 3) ? 8'd0 : 8'(LINE_WORDS - 1);
        exp_aw_addr = (kind == 4) ? word_addr : line_addr;
        exp_aw_len  = (kind == 4) ? 8'd0 : 8'(LINE_WORDS - 1);
        exp_aw_size = (kind == 4) ? expected_size(strb) : 3'd2;
        exp_wstrb   = (kind == 4) ? strb : 4'hf;
        if (kind == 1 || kind == 2) begin
            for (int k = 0; k < LINE_WORDS; k++) ref_mem[base + k] = old_line[k*32 +: 32];
        end
        if (kind == 4) ref_mem[widx] = merge_bytes(ref_mem[widx], data, strb);

        dref_cnt   = 0;
        uref_cnt   = 0;
        b_start    = b_count;
        ar_start   = ar_count;
        aw_start   = aw_count;
        prev_rdata = uncache_rdata;

        @(posedge clk);
        #1;
        dcache_ren      = (kind == 0 || kind == 2);
        dcache_wen      = (kind == 1 || kind == 2);
        dcache_raddr    = (kind == 1) ? word_addr : line_addr;
        dcache_waddr    = (kind == 0) ? word_addr : line_addr;
        dcache_line_old = old_line;
        uncache_en      = (kind >= 3) || noise;
        uncache_wen     = (kind == 3) ? 4'h0 : strb;
        uncache_addr    = word_addr;
        uncache_wdata   = data;
        @(posedge clk);
        #1;
        dcache_ren = 1'b0;
        dcache_wen = 1'b0;
        uncache_en = 1'b0;

        if (kind == 1) begin
            do @(posedge clk); while (b_count == b_start); // no flag for writeback only
        end else if (kind == 0 || kind == 2) begin
            do @(posedge clk); while (!dcache_refresh);
            for (int k = 0; k < LINE_WORDS; k++) begin
                assert (dcache_line_new[k*32 +: 32] === ref_mem[base + k])
                else flag_mismatch($sformatf("dcache_line_new[%0d]", k), ref_mem[base + k],
                                   dcache_line_new[k*32 +: 32]);
            end
        end else begin
            do @(posedge clk); while (!uncache_refresh);
            if (kind == 3) begin
                assert (uncache_rdata === ref_mem[widx])
                else flag_mismatch("uncache_rdata", ref_mem[widx], uncache_rdata);
            end else begin
                assert (uncache_rdata === prev_rdata)
                else flag_mismatch("uncache_rdata", prev_rdata, uncache_rdata);
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (ar_count - ar_start == int'(use_ar))
        else flag_mismatch("AR handshakes", use_ar, ar_count - ar_start);
        assert (aw_count - aw_start == int'(use_aw))
        else flag_mismatch("AW handshakes", use_aw, aw_count - aw_start);
        assert (dref_cnt == ((kind == 0 || kind == 2) ? 1 : 0))
        else flag_mismatch("dcache_refresh pulses", (kind == 0 || kind == 2), dref_cnt);
        assert (uref_cnt == ((kind >= 3) ? 1 : 0))
        else flag_mismatch("uncache_refresh pulses", (kind >= 3), uref_cnt);
        if (kind == 2) begin
            assert (b_time < ar_time)
            else abort_run("refill address was accepted before the writeback response");
        end
    endtask

    initial begin : stimulus
        int    kind;
        addr_t line_addr;
        addr_t word_addr;
        strb_t strb;
        word_t data;
        rst             = 1'b1;
        dcache_ren      = 1'b0;
        dcache_raddr    = '0;
        dcache_wen      = 1'b0;
        dcache_waddr    = '0;
        dcache_line_old = '0;
        uncache_en      = 1'b0;
        uncache_wen     = '0;
        uncache_addr    = '0;
        uncache_wdata   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = 32'h5a00_0000 ^ (i * 32'h0001_0004); // differs in every address bit
            ref_mem[i] = mem[i];
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert ({arvalid, rready, awvalid, wvalid, wlast, bready,
                     dcache_refresh, uncache_refresh} === 8'h00)
            else flag_mismatch("idle outputs after reset", 32'h0,
                               {arvalid, rready, awvalid, wvalid, wlast, bready,
                                dcache_refresh, uncache_refresh});
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            kind      = ($random(seed) & 32'h7fff_ffff) % 5;
            line_addr = addr_t'(($random(seed) & 15) << 6);  // 16 lines so ops overlap
            word_addr = addr_t'(($random(seed) & 255) << 2);
            strb      = strb_t'($random(seed));
            data      = $random(seed);
            if (kind == 4 && strb == 4'h0) strb = 4'b0001;
            run_op(kind, line_addr, word_addr, strb, data);
            if (kind == 4) run_op(3, line_addr, word_addr, strb, data); // read back merge
        end

        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem[i] === ref_mem[i])
            else flag_mismatch($sformatf("mem[%0d]", i), ref_mem[i], mem[i]);
        end

        if (u_dut.u_bus_asserts.error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("bus protocol assertions reported errors");
        end
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        abort_run("timeout: the bridge did not finish all operations in time");
    end

endmodule

/* vlog.f */
hdl/bridge_pkg.sv
hdl/bridge_ifs.sv
hdl/req_capture.sv
hdl/burst_read_engine.sv
hdl/burst_write_engine.sv
hdl/resp_deliver.sv
hdl/bus_bridge_top.sv
test/bus_bridge_asserts.sv
test/tb_bus_bridge.sv
